// File: all.f
hdl/psram_pkg.sv
hdl/wb_pkg.sv
hdl/psram_timing_regs.sv
hdl/psram_async_ctrl.sv
hdl/psram_async_model.sv
hdl/psram_subsys_top.sv
verif/psram_subsys_tb.sv

// File: Bender.yml
package:
  name: psram_subsys

sources:
  # packages first, then the blocks and the top level
  - hdl/psram_pkg.sv
  - hdl/wb_pkg.sv
  - hdl/psram_timing_regs.sv
  - hdl/psram_async_ctrl.sv
  - hdl/psram_async_model.sv
  - hdl/psram_subsys_top.sv

  # testbench, top module psram_subsys_tb
  - target: test
    files:
      - verif/psram_subsys_tb.sv

// File: verif/psram_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module psram_subsys_tb;

    localparam int addr_width = 23;
    localparam int mem_depth = 65536;
    localparam int clk_half = 20;
    localparam int drive_delay = 2;
    localparam int ack_timeout = 200;
    localparam int poll_limit = 50;
    localparam int random_ops = 200;
    localparam int reset_latency = 4;
    localparam int new_latency = 9;
    localparam int new_hold = 3;

    logic            clk;
    logic            reset;
    wb_pkg::wb_req_t mem_req;
    wb_pkg::wb_rsp_t mem_rsp;
    wb_pkg::wb_req_t cfg_req;
    wb_pkg::wb_rsp_t cfg_rsp;

    // expected device contents, indexed after address wrap
    logic [15:0]     ref_mem [mem_depth] = '{default: '0};

    psram_subsys_top #(
        .addr_width (addr_width),
        .mem_depth  (mem_depth)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .mem_wb_req (mem_req),
        .mem_wb_rsp (mem_rsp),
        .cfg_wb_req (cfg_req),
        .cfg_wb_rsp (cfg_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // the controller keeps addr_width bits and the device wraps at its depth
    function automatic int ref_index(input logic [31:0] adr);
        return int'((adr % (32'd1 << addr_width)) % mem_depth);
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // **************************************************
    // bus cycles
    // **************************************************
    task automatic bus_cycle(input bit cfg_port, input logic we, input logic [31:0] adr,
                             input logic [15:0] dat, input logic [1:0] sel,
                             output logic [15:0] rdata, output int cycles);
        wb_pkg::wb_req_t req;
        wb_pkg::wb_rsp_t rsp;
        bit              acked;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        acked = 1'b0;
        cycles = 0;
        @(posedge clk);
        #drive_delay;
        if (cfg_port) begin
            cfg_req = req;
        end else begin
            mem_req = req;
        end
        // ack is registered, so look at it half a period after the edge
        while (!acked) begin
            @(negedge clk);
            cycles++;
            rsp = cfg_port ? cfg_rsp : mem_rsp;
            if (rsp.ack) begin
                acked = 1'b1;
            end else if (cycles >= ack_timeout) begin
                $display("%s port hung with no ack after %0d cycles at %0t ns",
                         cfg_port ? "config" : "memory", ack_timeout, $time);
                abort_run();
            end
        end
        rdata = rsp.dat;
        @(posedge clk);
        #drive_delay;
        if (cfg_port) begin
            cfg_req = '0;
        end else begin
            mem_req = '0;
        end
    endtask

    task automatic wb_mem_write(input logic [31:0] adr, input logic [15:0] dat,
                                input logic [1:0] sel);
        logic [15:0] unused_rd;
        int          cycles;
        int          idx;
        bus_cycle(1'b0, 1'b1, adr, dat, sel, unused_rd, cycles);
        idx = ref_index(adr);
        if (sel[0]) begin
            ref_mem[idx][7:0] = dat[7:0];
        end
        if (sel[1]) begin
            ref_mem[idx][15:8] = dat[15:8];
        end
    endtask

    task automatic wb_mem_read(input logic [31:0] adr, input logic [1:0] sel,
                               output logic [15:0] rdata, output int cycles);
        bus_cycle(1'b0, 1'b0, adr, 16'h0000, sel, rdata, cycles);
    endtask

    task automatic wb_cfg_write(input logic [31:0] offset, input logic [15:0] dat);
        logic [15:0] unused_rd;
        int          cycles;
        bus_cycle(1'b1, 1'b1, offset, dat, 2'b11, unused_rd, cycles);
    endtask

    task automatic wb_cfg_read(input logic [31:0] offset, output logic [15:0] rdata);
        int cycles;
        bus_cycle(1'b1, 1'b0, offset, 16'h0000, 2'b11, rdata, cycles);
    endtask

    // only the selected byte lanes of a read carry data
    task automatic read_and_compare(input logic [31:0] adr, input logic [1:0] sel);
        logic [15:0] got;
        logic [15:0] mask;
        int          cycles;
        mask = {{8{sel[1]}}, {8{sel[0]}}};
        wb_mem_read(adr, sel, got, cycles);
        check_word($sformatf("memory word at %h", adr), got & mask,
                   ref_mem[ref_index(adr)] & mask);
    endtask

    task automatic wait_config_idle();
        logic [15:0] status;
        int          polls;
        polls = 0;
        status = 16'h0001;
        while (status[wb_pkg::status_busy_bit]) begin
            if (polls >= poll_limit) begin
                $display("configuration update still busy after %0d status reads", poll_limit);
                abort_run();
            end
            wb_cfg_read(wb_pkg::reg_status_offset, status);
            polls++;
        end
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic verify_reset_state();
        psram_pkg::psram_bcr_t bcr_word;
        logic [15:0]           rd;
        wb_cfg_read(wb_pkg::reg_hold_offset, rd);
        check_word("hold register after reset", rd, 16'h0000);
        wb_cfg_read(wb_pkg::reg_bcr_offset, rd);
        bcr_word = rd;
        check_word("bcr latency after reset", 16'(bcr_word.latency), 16'(reset_latency));
        wait_config_idle();
        read_and_compare(32'h0000_1234, 2'b11);
    endtask

    task automatic word_roundtrip();
        logic [31:0] addrs [6] = '{32'd0, 32'd1, 32'd100, 32'd4095, 32'd65535, 32'd42};
        logic [15:0] rd;
        int          cycles;
        foreach (addrs[i]) begin
            wb_mem_write(addrs[i], addrs[i][15:0] ^ 16'h5a5a, 2'b11);
        end
        foreach (addrs[i]) begin
            read_and_compare(addrs[i], 2'b11);
        end
        // one depth above an address lands on the same word
        wb_mem_write(mem_depth + 42, 16'hbeef, 2'b11);
        wb_mem_read(32'd42, 2'b11, rd, cycles);
        check_word("aliased word at 42", rd, 16'hbeef);
        wb_mem_read(mem_depth + 1, 2'b11, rd, cycles);
        check_word("aliased read of word 1", rd, 16'h5a5b);
    endtask

    task automatic byte_lane_writes();
        logic [15:0] rd;
        int          cycles;
        wb_mem_write(32'd200, 16'ha5c3, 2'b11);
        wb_mem_write(32'd200, 16'h1234, 2'b01);
        wb_mem_read(32'd200, 2'b11, rd, cycles);
        check_word("low lane write", rd, 16'ha534);
        wb_mem_write(32'd200, 16'h5678, 2'b10);
        wb_mem_read(32'd200, 2'b11, rd, cycles);
        check_word("high lane write", rd, 16'h5634);
        read_and_compare(32'd200, 2'b11);
    endtask

    task automatic latency_change();
        psram_pkg::psram_bcr_t new_bcr;
        logic [15:0]           rd;
        int                    before_cycles;
        int                    after_cycles;
        int                    extra_cycles;
        wb_mem_write(32'd300, 16'h0f0f, 2'b11);
        wb_mem_read(32'd300, 2'b11, rd, before_cycles);
        check_word("word before the latency change", rd, 16'h0f0f);
        new_bcr = '0;
        new_bcr.latency = 4'(new_latency);
        new_bcr.wait_polarity = 1'b1;
        wb_cfg_write(wb_pkg::reg_bcr_offset, new_bcr);
        wb_cfg_write(wb_pkg::reg_hold_offset, 16'(new_hold));
        wait_config_idle();
        wb_cfg_read(wb_pkg::reg_hold_offset, rd);
        check_word("hold register", rd, 16'(new_hold));
        wb_cfg_read(wb_pkg::reg_bcr_offset, rd);
        check_word("bcr register", rd, new_bcr);
        wb_mem_write(32'd300, 16'hf00f, 2'b11);
        wb_mem_read(32'd300, 2'b11, rd, after_cycles);
        check_word("word after the latency change", rd, 16'hf00f);
        // every extra wait cycle and every hold cycle lengthens a read by one cycle
        extra_cycles = (new_latency - reset_latency) + new_hold;
        assert (after_cycles == before_cycles + extra_cycles) else begin
            $display("[FAIL] %0t ns: read took %0d cycles after the change, %0d before, %s %0d",
                     $time, after_cycles, before_cycles, "expected extra", extra_cycles);
            abort_run();
        end
    endtask

    task automatic random_traffic();
        logic [31:0] adr;
        logic [15:0] dat;
        logic [1:0]  sel;
        for (int i = 0; i < random_ops; i++) begin
            adr = ($urandom % 256) + ($urandom % 4) * mem_depth;
            sel = 2'($urandom_range(3, 1));
            if ($urandom % 2) begin
                dat = 16'($urandom);
                wb_mem_write(adr, dat, sel);
            end else begin
                read_and_compare(adr, sel);
            end
        end
    endtask

    initial begin
        void'($urandom(31));
        reset = 1'b1;
        mem_req = '0;
        cfg_req = '0;
        repeat (5) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        verify_reset_state();
        word_roundtrip();
        byte_lane_writes();
        latency_change();
        random_traffic();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/psram_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module psram_subsys_top #(
    parameter int addr_width = 23,
    parameter int mem_depth = 65536
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire wb_pkg::wb_req_t mem_wb_req,
    output wb_pkg::wb_rsp_t      mem_wb_rsp,
    input  wire wb_pkg::wb_req_t cfg_wb_req,
    output wb_pkg::wb_rsp_t      cfg_wb_rsp
);

    logic [3:0]                       hold_cycles;
    psram_pkg::psram_bcr_t            bcr;
    logic                             bcr_update;
    logic                             bcr_done;
    psram_pkg::psram_pins_t           pins;
    logic                             mem_wait;
    wire [psram_pkg::data_width-1:0]  data_bus;

    psram_timing_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_req     (cfg_wb_req),
        .cfg_rsp     (cfg_wb_rsp),
        .hold_cycles (hold_cycles),
        .bcr         (bcr),
        .bcr_update  (bcr_update),
        .bcr_done    (bcr_done)
    );

    psram_async_ctrl #(
        .addr_width (addr_width)
    ) u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .mem_req     (mem_wb_req),
        .mem_rsp     (mem_wb_rsp),
        .hold_cycles (hold_cycles),
        .bcr         (bcr),
        .bcr_update  (bcr_update),
        .bcr_done    (bcr_done),
        .pins        (pins),
        .mem_wait    (mem_wait),
        .data        (data_bus)
    );

    // behavioural stand-in for the pseudo-SRAM part
    psram_async_model #(
        .addr_width (addr_width),
        .mem_depth  (mem_depth)
    ) u_model (
        .clk      (clk),
        .reset    (reset),
        .pins     (pins),
        .mem_wait (mem_wait),
        .data     (data_bus)
    );

endmodule

`default_nettype wire

// File: hdl/psram_async_model.sv
`timescale 1ns/1ps
`default_nettype none

module psram_async_model #(
    parameter int addr_width = 23,
    parameter int mem_depth = 65536
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire psram_pkg::psram_pins_t     pins,
    output logic                            mem_wait,
    inout  wire [psram_pkg::data_width-1:0] data
);

    localparam int idx_width = $clog2(mem_depth);

    logic [psram_pkg::data_width-1:0]    mem [mem_depth] = '{default: '0};

    psram_pkg::psram_bcr_t               cfg;
    logic [psram_pkg::latency_width-1:0] lat_cnt;
    logic [psram_pkg::latency_width-1:0] start_lat;
    logic                                addr_strobe;
    logic                                expire;
    logic                                op_we;
    logic                                op_cre;
    logic                                op_ub_l;
    logic                                op_lb_l;
    logic [addr_width-1:0]               op_addr;
    logic [idx_width-1:0]                mem_idx;
    logic [psram_pkg::data_width-1:0]    dout;
    psram_pkg::psram_word_u              bus_word;
    psram_pkg::psram_word_u              cfg_word;

    // a new access is only sampled while the previous one is finished
    assign addr_strobe = !pins.ce_l && !pins.adv_l && !mem_wait;
    assign expire = mem_wait && (lat_cnt == 4'd1);

    // a latency of zero behaves as one
    assign start_lat = (cfg.latency == '0) ? 4'd1 : cfg.latency;

    // addresses past the array wrap around
    assign mem_idx = idx_width'(op_addr % mem_depth);

    assign bus_word.raw = data;
    assign cfg_word.bcr = cfg;

    // **************************************************
    // access control and configuration register
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wait <= 1'b0;
            lat_cnt <= '0;
            cfg <= psram_pkg::bcr_default;
            op_we <= 1'b0;
            op_cre <= 1'b0;
        end else if (mem_wait) begin
            if (expire) begin
                mem_wait <= 1'b0;
                if (op_cre && op_we) begin
                    cfg <= bus_word.bcr;
                end
            end else begin
                lat_cnt <= lat_cnt - 4'd1;
            end
        end else if (addr_strobe) begin
            mem_wait <= 1'b1;
            lat_cnt <= start_lat;
            op_we <= !pins.we_l;
            op_cre <= pins.cre;
        end
    end

    // **************************************************
    // array and output word
    // **************************************************
    always_ff @(posedge clk) begin
        if (addr_strobe) begin
            op_addr <= pins.addr[addr_width-1:0];
            op_ub_l <= pins.ub_l;
            op_lb_l <= pins.lb_l;
        end
        if (expire && !op_cre) begin
            if (op_we) begin
                if (!op_lb_l) begin
                    mem[mem_idx][7:0] <= data[7:0];
                end
                if (!op_ub_l) begin
                    mem[mem_idx][15:8] <= data[15:8];
                end
            end else begin
                dout <= mem[mem_idx];
            end
        end else if (expire && !op_we) begin
            // a cre read returns the configuration word
            dout <= cfg_word.raw;
        end
    end

    assign data = pins.oe_l ? 'z : dout;

endmodule

`default_nettype wire

// File: hdl/psram_async_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module psram_async_ctrl #(
    parameter int addr_width = 23
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire wb_pkg::wb_req_t                   mem_req,
    output wb_pkg::wb_rsp_t                        mem_rsp,
    input  wire [3:0]                              hold_cycles,
    input  wire psram_pkg::psram_bcr_t             bcr,
    input  wire                                    bcr_update,
    output logic                                   bcr_done,
    output psram_pkg::psram_pins_t                 pins,
    input  wire                                    mem_wait,
    inout  wire [psram_pkg::data_width-1:0]        data
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_wait,
        st_hold,
        st_finish
    } state_t;

    state_t                                  state;
    logic [3:0]                              hold_cnt;
    logic                                    ack_q;
    logic [psram_pkg::data_width-1:0]        rdata_q;
    logic                                    start_cfg;
    logic                                    start_mem;
    logic                                    op_we;
    logic                                    op_cre;
    logic [psram_pkg::pin_addr_width-1:0]    op_addr;
    logic [wb_pkg::wb_sel_width-1:0]         op_sel;
    psram_pkg::psram_word_u                  op_word;

    // a pending configuration update wins over a waiting memory cycle
    assign start_cfg = (state == st_idle) && bcr_update;
    assign start_mem = (state == st_idle) && !bcr_update && mem_req.cyc && mem_req.stb &&
                       !ack_q;

    // **************************************************
    // sequencer
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            hold_cnt <= '0;
            ack_q <= 1'b0;
            op_we <= 1'b0;
            op_cre <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_cfg) begin
                        op_we <= 1'b1;
                        op_cre <= 1'b1;
                        state <= st_addr;
                    end else if (start_mem) begin
                        op_we <= mem_req.we;
                        op_cre <= 1'b0;
                        state <= st_addr;
                    end
                end
                st_addr: state <= st_wait;
                st_wait: begin
                    if (!mem_wait) begin
                        if (hold_cycles == 4'd0) begin
                            state <= st_finish;
                        end else begin
                            hold_cnt <= hold_cycles - 4'd1;
                            state <= st_hold;
                        end
                    end
                end
                st_hold: begin
                    if (hold_cnt == 4'd0) begin
                        state <= st_finish;
                    end else begin
                        hold_cnt <= hold_cnt - 4'd1;
                    end
                end
                st_finish: begin
                    ack_q <= !op_cre;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request payload and read data capture
    always_ff @(posedge clk) begin
        if (start_cfg) begin
            op_addr <= '0;
            op_sel <= '1;
            op_word.bcr <= bcr;
        end else if (start_mem) begin
            op_addr <= psram_pkg::pin_addr_width'(mem_req.adr[addr_width-1:0]);
            op_sel <= mem_req.sel;
            op_word.raw <= mem_req.dat;
        end
        if (state == st_finish && !op_we) begin
            rdata_q <= data;
        end
    end

    // **************************************************
    // pin decode
    // **************************************************
    always_comb begin
        pins.addr = op_addr;
        pins.adv_l = 1'b1;
        pins.ce_l = 1'b1;
        pins.oe_l = 1'b1;
        pins.we_l = 1'b1;
        pins.ub_l = 1'b1;
        pins.lb_l = 1'b1;
        pins.cre = 1'b0;
        if (state != st_idle) begin
            pins.ce_l = 1'b0;
            pins.we_l = !op_we;
            pins.ub_l = !op_sel[1];
            pins.lb_l = !op_sel[0];
            pins.cre = op_cre;
        end
        if (state == st_addr) begin
            pins.adv_l = 1'b0;
        end
        // the device owns the bus through hold and the capture cycle of a read
        if ((state == st_hold || state == st_finish) && !op_we) begin
            pins.oe_l = 1'b0;
        end
    end

    assign data = pins.oe_l ? op_word.raw : 'z;

    assign bcr_done = (state == st_finish) && op_cre;

    assign mem_rsp.ack = ack_q;
    assign mem_rsp.dat = rdata_q;

endmodule

`default_nettype wire

// File: hdl/psram_timing_regs.sv
`timescale 1ns/1ps
`default_nettype none

module psram_timing_regs (
    input  wire                   clk,
    input  wire                   reset,
    input  wire wb_pkg::wb_req_t  cfg_req,
    output wb_pkg::wb_rsp_t       cfg_rsp,
    output logic [3:0]            hold_cycles,
    output psram_pkg::psram_bcr_t bcr,
    output logic                  bcr_update,
    input  wire                   bcr_done
);

    logic                                 accept;
    logic                                 cfg_ack;
    logic [wb_pkg::wb_data_width-1:0]     cfg_rdata;
    logic [wb_pkg::wb_data_width-1:0]     read_word;
    logic [wb_pkg::reg_offset_bits-1:0]   offset;

    assign offset = cfg_req.adr[wb_pkg::reg_offset_bits-1:0];

    // a new cycle is taken only once the previous ack has gone out
    assign accept = cfg_req.cyc && cfg_req.stb && !cfg_ack;

    always_comb begin
        read_word = '0;
        case (offset)
            wb_pkg::reg_hold_offset: read_word[3:0] = hold_cycles;
            wb_pkg::reg_bcr_offset: read_word = bcr;
            wb_pkg::reg_status_offset: read_word[wb_pkg::status_busy_bit] = bcr_update;
            default: read_word = '0;
        endcase
    end

    // bcr_update comes up after reset so the device picks up the register value
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_ack <= 1'b0;
            hold_cycles <= '0;
            bcr <= psram_pkg::bcr_default;
            bcr_update <= 1'b1;
        end else begin
            cfg_ack <= accept;
            if (bcr_done) begin
                bcr_update <= 1'b0;
            end
            if (accept && cfg_req.we) begin
                case (offset)
                    wb_pkg::reg_hold_offset: hold_cycles <= cfg_req.dat[3:0];
                    wb_pkg::reg_bcr_offset: begin
                        bcr <= cfg_req.dat;
                        // a new word overrides a done arriving in the same cycle
                        bcr_update <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_rdata <= read_word;
        end
    end

    assign cfg_rsp.ack = cfg_ack;
    assign cfg_rsp.dat = cfg_rdata;

endmodule

`default_nettype wire

// File: hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int wb_data_width = 16;
    localparam int wb_addr_width = 32;
    localparam int wb_sel_width = wb_data_width / 8;

    // classic cycle request, held by the master until ack
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [wb_addr_width-1:0] adr;
        logic [wb_data_width-1:0] dat;
        logic [wb_sel_width-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [wb_data_width-1:0] dat;
    } wb_rsp_t;

    // **************************************************
    // register map, word offsets on the config port
    // **************************************************
    localparam int reg_offset_bits = 2;

    localparam logic [reg_offset_bits-1:0] reg_hold_offset = 2'd0;
    localparam logic [reg_offset_bits-1:0] reg_bcr_offset = 2'd1;
    localparam logic [reg_offset_bits-1:0] reg_status_offset = 2'd2;

    // status bit set while a configuration update is pending
    localparam int status_busy_bit = 0;

endpackage

`default_nettype wire

// File: hdl/psram_pkg.sv
`default_nettype none

package psram_pkg;

    localparam int data_width = 16;
    localparam int pin_addr_width = 23;
    localparam int latency_width = 4;

    // device default latency after reset
    localparam logic [latency_width-1:0] bcr_reset_latency = 4'd4;

    // configuration word as the device stores it
    typedef struct packed {
        logic [data_width-latency_width-2:0] reserved;
        logic                                wait_polarity;
        logic [latency_width-1:0]            latency;
    } psram_bcr_t;

    // the same bus word is plain data or, with cre set, the configuration word
    typedef union packed {
        logic [data_width-1:0] raw;
        psram_bcr_t            bcr;
    } psram_word_u;

    // device pins, all strobes active low except cre
    typedef struct packed {
        logic [pin_addr_width-1:0] addr;
        logic                      adv_l;
        logic                      ce_l;
        logic                      oe_l;
        logic                      we_l;
        logic                      ub_l;
        logic                      lb_l;
        logic                      cre;
    } psram_pins_t;

    localparam psram_bcr_t bcr_default = '{
        reserved:      '0,
        wait_polarity: 1'b0,
        latency:       bcr_reset_latency
    };

endpackage

`default_nettype wire
